//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ramio_tb
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- common/io_if.sv
// ##########################################################################
// io_if: steering stage to I/O register block connection
// ##########################################################################

`timescale 1ns/1ns

interface io_if ();

  // single cycle strobes, already qualified by address and byte size
  logic       led_write;
  logic       tx_write;
  logic       rx_read;
  logic [7:0] write_byte;

  // register contents presented back for reads
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;

  modport steer (
    output led_write, tx_write, rx_read, write_byte,
    input  tx_byte, rx_byte
  );

  modport io (
    input  led_write, tx_write, rx_read, write_byte,
    output tx_byte, rx_byte
  );

endinterface

//--- common/mem_if.sv
// ##########################################################################
// mem_if: steering stage to word RAM connection
// ##########################################################################

`timescale 1ns/1ns

interface mem_if import ramio_pkg::*; #(
  parameter int ram_addr_width = 10
) ();

  logic                      enable;
  logic [ram_addr_width-1:0] word_address;
  // one bit per byte lane, all zero on a read
  logic [data_width/8-1:0]   write_enable;
  logic [data_width-1:0]     write_data;
  logic [data_width-1:0]     read_data;
  logic                      read_valid;

  modport steer (
    output enable, word_address, write_enable, write_data,
    input  read_data, read_valid
  );

  modport ram (
    input  enable, word_address, write_enable, write_data,
    output read_data, read_valid
  );

endinterface

//--- common/ramio_pkg.sv
// ##########################################################################
// ramio shared definitions
// access size encoding, client data and address widths, I/O address map
// ##########################################################################

package ramio_pkg;

  // encoding of write_type and of read_type[1:0]
  // read_type[2] selects sign extension on reads
  typedef enum logic [1:0] {
    size_none = 2'b00,
    size_byte = 2'b01,
    size_half = 2'b10,
    size_word = 2'b11
  } access_size_t;

  // client side widths
  localparam int data_width = 32;
  localparam int addr_width = 32;

  // I/O registers sit at the very top of the byte address space
  // led register, low nibble of a byte write
  localparam logic [addr_width-1:0] addr_led = '1;

  // uart transmit byte, byte write starts a frame
  localparam logic [addr_width-1:0] addr_uart_out = addr_led - 1;

  // uart receive byte, cleared by a byte read
  localparam logic [addr_width-1:0] addr_uart_in = addr_led - 2;

endpackage

//--- compile.f
common/ramio_pkg.sv
common/mem_if.sv
common/io_if.sv
hdl/word_ram.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/io_regs.sv
hdl/ramio.sv
dv/tb_clock.sv
dv/ramio_tb.sv

//--- dv/ramio_tb.sv
// ##########################################################################
// ramio_tb: testbench for the load/store port
// RAM and I/O accesses checked against a shadow model and reference
// function, plus a UART line driver and frame decoder
// ##########################################################################

`timescale 1ns/1ns

module ramio_tb import ramio_pkg::*;;

  // upper bound on accesses issued, sizes the watchdog
  localparam int n_accesses     = 250;
  localparam int timeout_cycles = 2 * (n_accesses * 4 + 4 * 100);

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  logic [1:0]  write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic        uart_rx;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic [3:0]  led;
  logic        uart_tx;

  // reference state
  logic [31:0] shadow [1024];
  logic [3:0]  led_model;
  logic [7:0]  tx_model;
  logic [7:0]  rx_model;
  logic [31:0] exp_data;

  tb_clock #(.period(100), .reset_cycles(5)) clock_i (.clk(clk), .rst_n(rst_n));

  ramio #(
    .ram_addr_width(10),
    .clk_hz        (10_000_000),
    .baud_rate     (1_000_000)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .read_type     (read_type),
    .write_type    (write_type),
    .address       (address),
    .data_in       (data_in),
    .uart_rx       (uart_rx),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .led           (led),
    .uart_tx       (uart_tx)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      fail_run($sformatf("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  function automatic logic io_address(input logic [31:0] addr);
    return addr == addr_led || addr == addr_uart_out || addr == addr_uart_in;
  endfunction

  // expected data_out for a read, from the shadow contents and I/O model
  function automatic logic [31:0] expected_read(input logic [31:0] addr, input logic [2:0] rtype);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    logic        sgn;
    sgn  = rtype[2];
    word = shadow[addr[11:2]];
    if (addr == addr_uart_out) b = tx_model;
    else if (addr == addr_uart_in) b = rx_model;
    else if (addr == addr_led) b = 8'h00;
    else b = word[8*addr[1:0] +: 8];
    h = addr[1] ? word[31:16] : word[15:0];
    case (rtype[1:0])
      2'b01: return {{24{sgn && b[7]}}, b};
      // halves need an even offset, words a zero offset
      2'b10: if (!io_address(addr) && !addr[0]) return {{16{sgn && h[15]}}, h};
      2'b11: if (!io_address(addr) && addr[1:0] == 2'b00) return word;
      default: ;
    endcase
    return 32'h0;
  endfunction

  // apply a write to the model, misaligned writes change nothing
  task automatic model_write(input logic [31:0] addr, input logic [1:0] wtype,
                             input logic [31:0] wdata);
    if (addr == addr_led) begin
      if (wtype == size_byte) led_model = wdata[3:0];
    end else if (addr == addr_uart_out) begin
      if (wtype == size_byte) tx_model = wdata[7:0];
    end else if (!io_address(addr)) begin
      if (wtype == size_byte) shadow[addr[11:2]][8*addr[1:0] +: 8] = wdata[7:0];
      if (wtype == size_half && !addr[0]) shadow[addr[11:2]][16*addr[1] +: 16] = wdata[15:0];
      if (wtype == size_word && addr[1:0] == 2'b00) shadow[addr[11:2]] = wdata;
    end
  endtask

  // one client access, held until data_out_ready, then released
  task automatic access(input logic [31:0] addr, input logic [2:0] rtype,
                        input logic [1:0] wtype, input logic [31:0] wdata);
    int cycles;
    int want;
    want = io_address(addr) ? 0 : 1;
    @(posedge clk);
    #10;
    // reply reflects memory before this access
    exp_data   = expected_read(addr, rtype);
    enable     = 1'b1;
    address    = addr;
    read_type  = rtype;
    write_type = wtype;
    data_in    = wdata;
    cycles     = 0;
    @(negedge clk);
    while (!data_out_ready && cycles < 8) begin
      cycles++;
      @(negedge clk);
    end
    assert (data_out_ready) else begin
      fail_run($sformatf("no reply to the access at address %h", addr));
    end
    assert (cycles == want) else begin
      fail_run($sformatf("MISMATCH at %0t ns: data_out_ready latency expected %0d got %0d",
                         $time, want, cycles));
    end
    model_write(addr, wtype, wdata);
    // byte read of uart in clears it
    if (addr == addr_uart_in && rtype[1:0] == size_byte) rx_model = 8'h00;
    @(posedge clk);
    #10;
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = 2'b00;
  endtask

  // drive one 8N1 frame, ten clocks per bit
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #10;
      uart_rx = bits[i];
      repeat (9) @(posedge clk);
    end
  endtask

  // decode one frame from uart_tx, sampling near mid bit on falling clock
  task automatic decode_frame(output logic [7:0] b);
    @(negedge uart_tx);
    repeat (5) @(negedge clk);
    assert (uart_tx === 1'b0) else fail_run("uart_tx start bit was not low at mid bit");
    for (int i = 0; i < 8; i++) begin
      repeat (10) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (10) @(negedge clk);
    assert (uart_tx === 1'b1) else fail_run("uart_tx stop bit was not high");
  endtask

  // compare every reply
  always @(negedge clk) begin
    if (enable && data_out_ready) check_value("data_out", exp_data, data_out);
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    fail_run("timeout: the tests did not finish in the allowed time");
  end

  initial begin
    int          idx;
    int          off;
    logic [31:0] a;
    logic [7:0]  seen;
    void'($urandom(32'h16f7_4a72));
    enable     = 1'b0;
    read_type  = 3'b000;
    write_type = 2'b00;
    address    = 32'h0;
    data_in    = 32'h0;
    uart_rx    = 1'b1;
    led_model  = 4'b1111;
    tx_model   = 8'h00;
    rx_model   = 8'h00;
    wait (rst_n === 1'b1);
    check_value("led", 32'(led_model), 32'(led));

    // word write then every aligned read, signed and unsigned
    access(32'h10, 3'b000, size_word, 32'h8F12_F3A4);
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) access(32'(16 + o), {s[0], 2'b01}, 2'b00, 32'h0);
    end
    for (int o = 0; o < 2; o++) begin
      for (int s = 0; s < 2; s++) access(32'(16 + 2 * o), {s[0], 2'b10}, 2'b00, 32'h0);
    end
    access(32'h10, 3'b011, 2'b00, 32'h0);
    access(32'h10, 3'b111, 2'b00, 32'h0);

    // lane merges, misaligned writes and reads
    access(32'h20, 3'b000, size_word, 32'h1122_3344);
    access(32'h21, 3'b000, size_byte, 32'h0000_00EE);
    access(32'h22, 3'b000, size_half, 32'h0000_BEEF);
    access(32'h23, 3'b000, size_half, 32'h0000_DEAD);
    access(32'h21, 3'b000, size_word, 32'hCAFE_F00D);
    access(32'h20, 3'b011, 2'b00, 32'h0);
    access(32'h21, 3'b110, 2'b00, 32'h0);
    access(32'h22, 3'b011, 2'b00, 32'h0);
    access(32'h21, 3'b101, 2'b00, 32'h0);

    // random traffic over sixteen words, all filled first
    for (int w = 0; w < 16; w++) access(32'(w * 4), 3'b000, size_word, $urandom);
    for (int n = 0; n < 200; n++) begin
      idx = int'($urandom % 16);
      off = int'($urandom % 4);
      a   = 32'(idx * 4 + off);
      if ($urandom % 2 == 0) access(a, 3'($urandom), 2'b00, 32'h0);
      else access(a, 3'b000, 2'(1 + $urandom % 3), $urandom);
    end

    // led register, byte writes only
    access(addr_led, 3'b000, size_byte, 32'h0000_005A);
    check_value("led", 32'(led_model), 32'(led));
    access(addr_led, 3'b000, size_word, 32'h0000_0003);
    check_value("led", 32'(led_model), 32'(led));
    access(addr_led, 3'b001, 2'b00, 32'h0);

    // uart transmit, frame decoded while the byte is read back
    fork
      decode_frame(seen);
      begin
        access(addr_uart_out, 3'b000, size_byte, 32'h0000_005C);
        access(addr_uart_out, 3'b001, 2'b00, 32'h0);
      end
    join
    check_value("uart_tx frame", 32'h5C, 32'(seen));
    repeat (10) @(posedge clk);
    tx_model = 8'h00;
    access(addr_uart_out, 3'b001, 2'b00, 32'h0);

    // uart receive, signed then unsigned
    send_frame(8'hA5);
    repeat (5) @(posedge clk);
    rx_model = 8'hA5;
    access(addr_uart_in, 3'b101, 2'b00, 32'h0);
    access(addr_uart_in, 3'b101, 2'b00, 32'h0);
    send_frame(8'hC3);
    repeat (5) @(posedge clk);
    rx_model = 8'hC3;
    access(addr_uart_in, 3'b001, 2'b00, 32'h0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
// ##########################################################################
// tb_clock: testbench clock and active low reset generator
// ##########################################################################

`timescale 1ns/1ns

module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release just after an edge, in step with the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #10;
    rst_n = 1'b1;
  end

endmodule

//--- hdl/io_regs.sv
// ##########################################################################
// io_regs: LED, uart transmit and uart receive registers
// runs the go level handshakes with the two uart blocks
// ##########################################################################

`timescale 1ns/1ns

module io_regs #(
  parameter int clk_hz    = 10_000_000,
  parameter int baud_rate = 1_000_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic [3:0] led,
  output logic       uart_tx,
  io_if.io           io
);

  logic [7:0] tx_byte;
  logic       tx_go;
  logic       tx_busy;
  logic [7:0] rx_byte;
  logic       rx_go;
  logic [7:0] rx_data;
  logic       rx_ready;

  assign io.tx_byte = tx_byte;
  assign io.rx_byte = rx_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // leds are active low, all off
      led     <= 4'b1111;
      tx_byte <= '0;
      tx_go   <= 1'b0;
      rx_byte <= '0;
      rx_go   <= 1'b1;
    end else begin
      if (io.led_write) led <= io.write_byte[3:0];

      // frame finished, release go and clear the byte in flight
      if (tx_go && !tx_busy) begin
        tx_go   <= 1'b0;
        tx_byte <= '0;
      end
      // a new write wins over the clear
      if (io.tx_write) begin
        tx_byte <= io.write_byte;
        tx_go   <= 1'b1;
      end

      // read clears first, the waiting byte is taken next cycle
      if (io.rx_read) begin
        rx_byte <= '0;
      end else if (rx_go && rx_ready) begin
        // overwrites an unread byte
        rx_byte <= rx_data;
        rx_go   <= 1'b0;
      end
      // go low for exactly one cycle as the acknowledge
      if (!rx_go) rx_go <= 1'b1;
    end
  end

  uart_tx #(
    .clk_hz   (clk_hz),
    .baud_rate(baud_rate)
  ) tx_i (
    .clk  (clk),
    .rst_n(rst_n),
    .go   (tx_go),
    .data (tx_byte),
    .tx   (uart_tx),
    .busy (tx_busy)
  );

  uart_rx #(
    .clk_hz   (clk_hz),
    .baud_rate(baud_rate)
  ) rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (uart_rx),
    .go        (rx_go),
    .data      (rx_data),
    .data_ready(rx_ready)
  );

endmodule

//--- hdl/ramio.sv
// ##########################################################################
// ramio: memory mapped load/store port for a 32-bit core
// decodes I/O addresses, places write lanes, extracts and extends reads
// and picks the reply between the word RAM and the I/O registers
// ##########################################################################

`timescale 1ns/1ns

module ramio import ramio_pkg::*; #(
  parameter int ram_addr_width = 10,
  parameter int clk_hz         = 10_000_000,
  parameter int baud_rate      = 1_000_000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  logic [2:0]            read_type,
  input  logic [1:0]            write_type,
  input  logic [addr_width-1:0] address,
  input  logic [data_width-1:0] data_in,
  input  logic                  uart_rx,
  output logic [data_width-1:0] data_out,
  output logic                  data_out_ready,
  output logic [3:0]            led,
  output logic                  uart_tx
);

  mem_if #(.ram_addr_width(ram_addr_width)) mem ();
  io_if io ();

  access_size_t rd_size;
  access_size_t wr_size;
  logic         rd_signed;
  logic [1:0]   offset;
  logic         is_led;
  logic         is_uart_out;
  logic         is_uart_in;
  logic         is_io;
  logic [7:0]   sel_byte;
  logic [15:0]  sel_half;

  assign rd_size   = access_size_t'(read_type[1:0]);
  assign wr_size   = access_size_t'(write_type);
  assign rd_signed = read_type[2];
  assign offset    = address[1:0];

  // address decode
  assign is_led      = address == addr_led;
  assign is_uart_out = address == addr_uart_out;
  assign is_uart_in  = address == addr_uart_in;
  assign is_io       = is_led || is_uart_out || is_uart_in;

  // I/O strobes only for byte accesses
  assign io.led_write  = enable && is_led && wr_size == size_byte;
  assign io.tx_write   = enable && is_uart_out && wr_size == size_byte;
  assign io.rx_read    = enable && is_uart_in && rd_size == size_byte;
  assign io.write_byte = data_in[7:0];

  // RAM sees every non-I/O access
  assign mem.enable       = enable && !is_io;
  assign mem.word_address = address[ram_addr_width+1:2];

  // write lanes, data replicated so each lane finds its bytes in place
  always_comb begin
    mem.write_enable = '0;
    mem.write_data   = '0;
    if (mem.enable) begin
      unique case (wr_size)
        size_none: ;
        size_byte: begin
          mem.write_enable = 4'b0001 << offset;
          mem.write_data   = {4{data_in[7:0]}};
        end
        size_half: begin
          // odd offset is misaligned, no lanes
          if (!offset[0]) begin
            mem.write_enable = offset[1] ? 4'b1100 : 4'b0011;
            mem.write_data   = {2{data_in[15:0]}};
          end
        end
        size_word: begin
          if (offset == 2'b00) begin
            mem.write_enable = 4'b1111;
            mem.write_data   = data_in;
          end
        end
      endcase
    end
  end

  // read extraction and extension
  always_comb begin
    sel_half = offset[1] ? mem.read_data[31:16] : mem.read_data[15:0];
    if (is_uart_out) sel_byte = io.tx_byte;
    else if (is_uart_in) sel_byte = io.rx_byte;
    // led register reads as zero
    else if (is_led) sel_byte = '0;
    else sel_byte = mem.read_data[8*offset +: 8];

    data_out = '0;
    if (enable) begin
      unique case (rd_size)
        size_none: ;
        size_byte: begin
          data_out = {{(data_width-8){rd_signed && sel_byte[7]}}, sel_byte};
        end
        size_half: begin
          // I/O half words and odd offsets give 0
          if (!is_io && !offset[0]) begin
            data_out = {{(data_width-16){rd_signed && sel_half[15]}}, sel_half};
          end
        end
        size_word: begin
          if (!is_io && offset == 2'b00) data_out = mem.read_data;
        end
      endcase
    end
  end

  // I/O answers at once, RAM after its one cycle latency
  assign data_out_ready = enable && (is_io || mem.read_valid);

  word_ram #(
    .ram_addr_width(ram_addr_width)
  ) ram_i (
    .clk  (clk),
    .rst_n(rst_n),
    .mem  (mem.ram)
  );

  io_regs #(
    .clk_hz   (clk_hz),
    .baud_rate(baud_rate)
  ) io_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .uart_rx(uart_rx),
    .led    (led),
    .uart_tx(uart_tx),
    .io     (io.io)
  );

endmodule

//--- hdl/word_ram.sv
// ##########################################################################
// on-chip word RAM with byte lane write enables
// registered read data and a registered read_valid flag
// ##########################################################################

`timescale 1ns/1ns

module word_ram import ramio_pkg::*; #(
  parameter int ram_addr_width = 10
) (
  input logic clk,
  input logic rst_n,
  mem_if.ram  mem
);

  localparam int lanes = data_width / 8;

  logic [data_width-1:0]     mem_array [2**ram_addr_width];
  // word index seen at the previous enabled edge
  logic [ram_addr_width-1:0] last_addr;

  // byte lane writes and the registered read port
  always_ff @(posedge clk) begin
    if (mem.enable) begin
      for (int i = 0; i < lanes; i++) begin
        if (mem.write_enable[i]) begin
          mem_array[mem.word_address][8*i +: 8] <= mem.write_data[8*i +: 8];
        end
      end
      // read before write so a write cycle returns the old word
      mem.read_data <= mem_array[mem.word_address];
      last_addr     <= mem.word_address;
    end
  end

  // valid one cycle after enable rises
  // an address change while enable is held restarts the latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem.read_valid <= 1'b0;
    end else begin
      mem.read_valid <= mem.enable &&
                        (!mem.read_valid || last_addr == mem.word_address);
    end
  end

endmodule

//--- uart/uart_rx.sv
// ##########################################################################
// uart_rx: 8N1 serial receiver with mid-bit sampling
// data_ready is held after a good frame until go falls
// ##########################################################################

`timescale 1ns/1ns

module uart_rx #(
  parameter int clk_hz    = 10_000_000,
  parameter int baud_rate = 1_000_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int bit_clks = clk_hz / baud_rate;
  localparam int cnt_w    = $clog2(bit_clks + 1);

  // two flop synchroniser plus one more stage for edge detect
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             active;
  // counts down to the next sample point
  logic [cnt_w-1:0] baud_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]       bit_cnt;
  logic [7:0]       shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      data       <= '0;
      data_ready <= 1'b0;
    end else begin
      // acknowledge from the owner
      if (data_ready && !go) data_ready <= 1'b0;
      if (!active) begin
        if (rx_prev && !rx_sync) begin
          // falling edge, first sample half a bit later
          active   <= 1'b1;
          baud_cnt <= cnt_w'(bit_clks / 2);
          bit_cnt  <= '0;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= cnt_w'(bit_clks - 1);
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd0) begin
          // glitch, start bit not low at mid period
          if (rx_sync) active <= 1'b0;
        end else if (bit_cnt == 4'd9) begin
          active <= 1'b0;
          // framing error drops the byte
          if (rx_sync) begin
            data       <= shift;
            data_ready <= 1'b1;
          end
        end else begin
          // lsb first
          shift <= {rx_sync, shift[7:1]};
        end
      end
    end
  end

endmodule

//--- uart/uart_tx.sv
// ##########################################################################
// uart_tx: 8N1 serial transmitter
// go starts a frame, busy stays high until the stop bit has ended
// ##########################################################################

`timescale 1ns/1ns

module uart_tx #(
  parameter int clk_hz    = 10_000_000,
  parameter int baud_rate = 1_000_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);

  localparam int bit_clks = clk_hz / baud_rate;
  localparam int cnt_w    = $clog2(bit_clks + 1);

  logic             active;
  // set once go has been seen low, so a held go sends only one frame
  logic             armed;
  logic [cnt_w-1:0] baud_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]       bit_cnt;
  logic [8:0]       shift;

  // busy rises in the same cycle go is accepted
  assign busy = active || (go && armed);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx       <= 1'b1;
      active   <= 1'b0;
      armed    <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      if (!go) armed <= 1'b1;
      if (!active) begin
        if (go && armed) begin
          // drive the start bit, keep data and stop bit queued
          active   <= 1'b1;
          armed    <= 1'b0;
          tx       <= 1'b0;
          shift    <= {1'b1, data};
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else if (baud_cnt == cnt_w'(bit_clks - 1)) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          // stop bit done, line already idle high
          active <= 1'b0;
        end else begin
          tx      <= shift[0];
          shift   <= {1'b1, shift[8:1]};
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule
